// File: rtl/nd_dma_pkg.sv
// ------------------------------
// Shared widths and dimension count of the ND DMA
// Request, response and error types
// Backend state encoding
// ------------------------------
`default_nettype none

package nd_dma_pkg;

    // Dimensions, including the inner 1D burst
    localparam int NUM_DIM = 3;
    // Word address width
    localparam int ADDR_W  = 16;
    // Burst length in words
    localparam int LEN_W   = 8;
    // Repetition counter width
    localparam int REP_W   = 4;
    // Data word width
    localparam int DATA_W  = 32;
    // Stride selector counting 0 .. NUM_DIM-1
    localparam int SEL_W   = $clog2(NUM_DIM);

    // ------------------------------
    // Enums
    // ------------------------------
    typedef enum logic [1:0] {
        ERR_NONE       = 2'd0,
        ERR_ND_ZERO    = 2'd1,  // a repetition count was zero
        ERR_BURST_ZERO = 2'd2   // a burst length was zero
    } err_type_e;

    // Backend FSM
    typedef enum logic [1:0] {
        BE_IDLE = 2'd0,
        BE_COPY = 2'd1,
        BE_RESP = 2'd2
    } be_state_e;

    // ------------------------------
    // Structs
    // ------------------------------
    // 1D burst of 41 bits
    typedef struct packed {
        logic [ADDR_W-1:0] src_addr;
        logic [ADDR_W-1:0] dst_addr;
        logic [LEN_W-1:0]  len;
        logic              last;
    } burst_req_t;

    // One outer dimension in 36 bits
    typedef struct packed {
        logic [REP_W-1:0]  reps;
        logic [ADDR_W-1:0] src_stride;
        logic [ADDR_W-1:0] dst_stride;
    } dim_cfg_t;

    // ND descriptor with dims[0] just outside the burst
    typedef struct packed {
        burst_req_t                  base;
        dim_cfg_t [NUM_DIM-2:0]      dims;
    } nd_req_t;

    // Response of 4 bits
    typedef struct packed {
        logic      error;
        err_type_e err_type;
        logic      last;
    } dma_rsp_t;

endpackage

`default_nettype wire

// File: rtl/nd_rep_counter.sv
// ------------------------------
// Repetition counter of one outer dimension
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module nd_rep_counter import nd_dma_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             en_i,
    input  wire logic             clear_i,
    input  wire logic [REP_W-1:0] limit_i,
    output logic                  done_o
);

    logic [REP_W-1:0] count_q;

    // Counts from 1 and clear wins over enable
    always_ff @(posedge clk_i) begin : proc_count
        if (!rst_n_i) begin
            count_q <= REP_W'(1);
        end else if (clear_i) begin
            count_q <= REP_W'(1);
        end else if (en_i) begin
            count_q <= count_q + REP_W'(1);
        end
    end

    // Final repetition of this dimension
    assign done_o = (count_q == limit_i);

    // Clear must arrive before the count runs past a real limit
    a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (limit_i != '0) |-> (count_q <= limit_i));

endmodule

`default_nettype wire

// File: rtl/nd_midend.sv
// ------------------------------
// ND midend
// Splits a descriptor into 1D bursts with strided addresses
// Filters burst responses and rejects zero repetitions
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module nd_midend import nd_dma_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // ND descriptor in
    input  wire nd_req_t    nd_req_i,
    input  wire logic       nd_req_valid_i,
    output logic            nd_req_ready_o,
    // ND response out
    output dma_rsp_t        nd_rsp_o,
    output logic            nd_rsp_valid_o,
    input  wire logic       nd_rsp_ready_i,
    // 1D burst to backend
    output burst_req_t      burst_req_o,
    output logic            burst_req_valid_o,
    input  wire logic       burst_req_ready_i,
    // 1D response from backend
    input  wire dma_rsp_t   burst_rsp_i,
    input  wire logic       burst_rsp_valid_i,
    output logic            burst_rsp_ready_o,
    output logic            busy_o
);

    // Stage chain with bit 0 as the descriptor itself
    logic [NUM_DIM-1:0] stage_done;
    logic [NUM_DIM-2:0] stage_zero;
    logic [NUM_DIM-2:0] stage_en;
    logic [NUM_DIM-2:0] stage_clear;
    logic [NUM_DIM-2:0] cnt_done;

    logic              zero;
    logic              last;
    logic              burst_fire;
    logic              rej_zero;
    logic              last_rsp_fire;
    logic [SEL_W-1:0]  stride_sel;
    logic [ADDR_W-1:0] src_stride;
    logic [ADDR_W-1:0] dst_stride;
    logic [ADDR_W-1:0] cur_src;
    logic [ADDR_W-1:0] cur_dst;

    // Running pointers where first_q selects the base addresses
    logic              first_q;
    logic [ADDR_W-1:0] src_addr_q;
    logic [ADDR_W-1:0] dst_addr_q;
    logic              rsp_pending_q;

    assign stage_done[0] = nd_req_valid_i;
    assign last          = &stage_done;
    // Any zero count kills the whole descriptor
    assign zero          = |stage_zero;
    assign rej_zero      = nd_req_valid_i & zero;

    assign burst_req_valid_o = nd_req_valid_i & ~zero;
    assign burst_fire        = burst_req_valid_o & burst_req_ready_i;
    // Consumed with the last burst, or at once when rejected
    assign nd_req_ready_o    = rej_zero | (burst_fire & last);

    // ------------------------------
    // Repetition counters
    // ------------------------------
    for (genvar d = 0; d < NUM_DIM-1; d++) begin : gen_dim
        // Step when every lower stage is on its final pass
        assign stage_en[d]    = (&stage_done[d:0]) & burst_fire;
        assign stage_clear[d] = (&stage_done[d+1:0]) & burst_fire;
        assign stage_zero[d]  = (nd_req_i.dims[d].reps == '0);

        // Zero count stage is bypassed
        assign stage_done[d+1] = stage_zero[d] ? (&stage_done[d:0]) : cnt_done[d];

        nd_rep_counter u_rep (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .en_i    (stage_en[d]),
            .clear_i (stage_clear[d]),
            .limit_i (nd_req_i.dims[d].reps),
            .done_o  (cnt_done[d])
        );
    end

    // ------------------------------
    // Stride selection
    // ------------------------------
    // Number of wrapping stages picks the stride
    always_comb begin : proc_stride_sel
        stride_sel = '0;
        for (int i = 0; i < NUM_DIM-1; i++) begin
            stride_sel = stride_sel + SEL_W'(stage_clear[i]);
        end
    end

    // All stages wrapping means the last burst with no stride needed
    always_comb begin : proc_stride_mux
        src_stride = '0;
        dst_stride = '0;
        for (int i = 0; i < NUM_DIM-1; i++) begin
            if (stride_sel == SEL_W'(i)) begin
                src_stride = nd_req_i.dims[i].src_stride;
                dst_stride = nd_req_i.dims[i].dst_stride;
            end
        end
    end

    assign cur_src = first_q ? nd_req_i.base.src_addr : src_addr_q;
    assign cur_dst = first_q ? nd_req_i.base.dst_addr : dst_addr_q;

    // Burst out straight from descriptor and pointers
    always_comb begin : proc_burst_out
        burst_req_o          = nd_req_i.base;
        burst_req_o.src_addr = cur_src;
        burst_req_o.dst_addr = cur_dst;
        burst_req_o.last     = last;
    end

    // ------------------------------
    // Pointer and busy state
    // ------------------------------
    assign last_rsp_fire = burst_rsp_valid_i & burst_rsp_i.last & burst_rsp_ready_o;

    always_ff @(posedge clk_i) begin : proc_ptr
        if (!rst_n_i) begin
            first_q       <= 1'b1;
            src_addr_q    <= '0;
            dst_addr_q    <= '0;
            rsp_pending_q <= 1'b0;
        end else begin
            if (burst_fire) begin
                // Back to base after the final burst
                first_q    <= last;
                src_addr_q <= cur_src + src_stride;
                dst_addr_q <= cur_dst + dst_stride;
            end
            // Last response still owed to the ND port
            if (burst_fire && last) begin
                rsp_pending_q <= 1'b1;
            end else if (last_rsp_fire) begin
                rsp_pending_q <= 1'b0;
            end
        end
    end

    assign busy_o = nd_req_valid_i | rsp_pending_q;

    // ------------------------------
    // Response filter
    // ------------------------------
    always_comb begin : proc_rsp
        nd_rsp_o          = burst_rsp_i;
        nd_rsp_valid_o    = burst_rsp_valid_i & burst_rsp_i.last;
        // Intermediate responses are dropped here
        burst_rsp_ready_o = burst_rsp_i.last ? nd_rsp_ready_i : 1'b1;
        if (rej_zero) begin
            // Hold the backend off while the error goes out
            burst_rsp_ready_o = 1'b0;
            nd_rsp_valid_o    = 1'b1;
            nd_rsp_o          = '{error: 1'b1, err_type: ERR_ND_ZERO, last: 1'b1};
        end
    end

    // Burst request is not withdrawn under a stable descriptor
    a_burst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (burst_req_valid_o && !burst_req_ready_i) ##1 $stable(nd_req_i)
        |-> burst_req_valid_o);

    // ND response only once the last burst is out or on a rejection
    a_rsp_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(nd_rsp_valid_o) |-> rsp_pending_q || rej_zero);

endmodule

`default_nettype wire

// File: rtl/burst_copy_backend.sv
// ------------------------------
// Word-copy backend
// Runs one 1D burst as reads and writes
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module burst_copy_backend import nd_dma_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    // Burst in
    input  wire burst_req_t        req_i,
    input  wire logic              req_valid_i,
    output logic                   req_ready_o,
    // Response out
    output dma_rsp_t               rsp_o,
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    // Source read port
    output logic [ADDR_W-1:0]      mem_raddr_o,
    output logic                   mem_re_o,
    input  wire logic [DATA_W-1:0] mem_rdata_i,
    // Destination write port
    output logic                   mem_we_o,
    output logic [ADDR_W-1:0]      mem_waddr_o,
    output logic [DATA_W-1:0]      mem_wdata_o
);

    be_state_e         state_q;
    logic [ADDR_W-1:0] rd_addr_q;
    logic [ADDR_W-1:0] wr_addr_q;
    logic [LEN_W-1:0]  rd_left_q;
    logic [LEN_W-1:0]  wr_left_q;
    // Read issued last cycle so its data is on mem_rdata_i now
    logic              we_q;
    logic              last_q;
    err_type_e         err_type_q;

    assign req_ready_o = (state_q == BE_IDLE);

    // One read per cycle while words remain
    assign mem_re_o    = (state_q == BE_COPY) && (rd_left_q != '0);
    assign mem_raddr_o = rd_addr_q;

    // Write trails its read by a cycle
    assign mem_we_o    = we_q;
    assign mem_waddr_o = wr_addr_q;
    assign mem_wdata_o = mem_rdata_i;

    assign rsp_valid_o    = (state_q == BE_RESP);
    assign rsp_o.error    = (err_type_q != ERR_NONE);
    assign rsp_o.err_type = err_type_q;
    assign rsp_o.last     = last_q;

    // ------------------------------
    // FSM and counters
    // ------------------------------
    always_ff @(posedge clk_i) begin : proc_fsm
        if (!rst_n_i) begin
            state_q    <= BE_IDLE;
            rd_addr_q  <= '0;
            wr_addr_q  <= '0;
            rd_left_q  <= '0;
            wr_left_q  <= '0;
            we_q       <= 1'b0;
            last_q     <= 1'b0;
            err_type_q <= ERR_NONE;
        end else begin
            we_q <= mem_re_o;
            case (state_q)
                BE_IDLE: begin
                    if (req_valid_i) begin
                        rd_addr_q <= req_i.src_addr;
                        wr_addr_q <= req_i.dst_addr;
                        rd_left_q <= req_i.len;
                        wr_left_q <= req_i.len;
                        last_q    <= req_i.last;
                        // Empty burst answers right away
                        if (req_i.len == '0) begin
                            err_type_q <= ERR_BURST_ZERO;
                            state_q    <= BE_RESP;
                        end else begin
                            err_type_q <= ERR_NONE;
                            state_q    <= BE_COPY;
                        end
                    end
                end
                BE_COPY: begin
                    if (mem_re_o) begin
                        rd_addr_q <= rd_addr_q + ADDR_W'(1);
                        rd_left_q <= rd_left_q - LEN_W'(1);
                    end
                    if (mem_we_o) begin
                        wr_addr_q <= wr_addr_q + ADDR_W'(1);
                        wr_left_q <= wr_left_q - LEN_W'(1);
                        // Final write goes out this cycle
                        if (wr_left_q == LEN_W'(1)) begin
                            state_q <= BE_RESP;
                        end
                    end
                end
                BE_RESP: begin
                    if (rsp_ready_i) begin
                        state_q <= BE_IDLE;
                    end
                end
                default: state_q <= BE_IDLE;
            endcase
        end
    end

    // No memory traffic while waiting for a burst
    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == BE_IDLE) |-> !mem_re_o && !mem_we_o);

    // Never more writes than len
    a_wr_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_we_o |-> (wr_left_q != '0));

    // And never fewer by the time the response shows
    a_wr_all: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(rsp_valid_o) |-> (wr_left_q == '0) && (rd_left_q == '0));

endmodule

`default_nettype wire

// File: rtl/nd_dma_top.sv
// ------------------------------
// ND DMA top level
// Midend feeding the word-copy backend
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module nd_dma_top import nd_dma_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    // ND request
    input  wire nd_req_t           nd_req_i,
    input  wire logic              nd_req_valid_i,
    output logic                   nd_req_ready_o,
    // ND response
    output dma_rsp_t               nd_rsp_o,
    output logic                   nd_rsp_valid_o,
    input  wire logic              nd_rsp_ready_i,
    // Source memory
    output logic [ADDR_W-1:0]      mem_raddr_o,
    output logic                   mem_re_o,
    input  wire logic [DATA_W-1:0] mem_rdata_i,
    // Destination memory
    output logic                   mem_we_o,
    output logic [ADDR_W-1:0]      mem_waddr_o,
    output logic [DATA_W-1:0]      mem_wdata_o,
    output logic                   busy_o
);

    // Midend to backend
    burst_req_t burst_req;
    logic       burst_req_valid;
    logic       burst_req_ready;
    dma_rsp_t   burst_rsp;
    logic       burst_rsp_valid;
    logic       burst_rsp_ready;

    nd_midend u_midend (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .nd_req_i          (nd_req_i),
        .nd_req_valid_i    (nd_req_valid_i),
        .nd_req_ready_o    (nd_req_ready_o),
        .nd_rsp_o          (nd_rsp_o),
        .nd_rsp_valid_o    (nd_rsp_valid_o),
        .nd_rsp_ready_i    (nd_rsp_ready_i),
        .burst_req_o       (burst_req),
        .burst_req_valid_o (burst_req_valid),
        .burst_req_ready_i (burst_req_ready),
        .burst_rsp_i       (burst_rsp),
        .burst_rsp_valid_i (burst_rsp_valid),
        .burst_rsp_ready_o (burst_rsp_ready),
        .busy_o            (busy_o)
    );

    burst_copy_backend u_backend (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (burst_req),
        .req_valid_i (burst_req_valid),
        .req_ready_o (burst_req_ready),
        .rsp_o       (burst_rsp),
        .rsp_valid_o (burst_rsp_valid),
        .rsp_ready_i (burst_rsp_ready),
        .mem_raddr_o (mem_raddr_o),
        .mem_re_o    (mem_re_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_we_o    (mem_we_o),
        .mem_waddr_o (mem_waddr_o),
        .mem_wdata_o (mem_wdata_o)
    );

endmodule

`default_nettype wire

// File: tb/nd_dma_checker.sv
// ------------------------------
// Checker of the ND DMA testbench
// Model of burst order, strides and source data
// Compares writes, responses and busy
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module nd_dma_checker import nd_dma_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire nd_req_t           nd_req_i,
    input  wire logic              nd_req_valid_i,
    input  wire logic              nd_req_ready_i,
    input  wire dma_rsp_t          nd_rsp_i,
    input  wire logic              nd_rsp_valid_i,
    input  wire logic              nd_rsp_ready_i,
    input  wire logic              mem_re_i,
    input  wire logic              mem_we_i,
    input  wire logic [ADDR_W-1:0] mem_waddr_i,
    input  wire logic [DATA_W-1:0] mem_wdata_i,
    input  wire logic              busy_i,
    input  wire logic              finish_i,
    output int                     err_cnt_o,
    output int                     done_cnt_o
);

    // Expected destination traffic of the open descriptor
    logic [ADDR_W-1:0] exp_waddr[$];
    logic [DATA_W-1:0] exp_wdata[$];
    dma_rsp_t          exp_rsp;
    // Response seen stalled last cycle
    dma_rsp_t          held_rsp;
    logic              held;
    logic              active;
    logic              accepted;
    logic              rsp_taken;
    logic              reset_checked;
    int                test_idx;
    int                test_errs;
    int                test_bursts;
    int                pass_cnt;
    int                fail_cnt;

    initial begin
        held          = 1'b0;
        active        = 1'b0;
        accepted      = 1'b0;
        rsp_taken     = 1'b0;
        reset_checked = 1'b0;
        test_idx      = 0;
        test_errs     = 0;
        test_bursts   = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        err_cnt_o     = 0;
        done_cnt_o    = 0;
    end

    // Source word as a mix of the whole address
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return {addr ^ 16'hC3A5, addr * 16'd13 + 16'h02F1};
    endfunction

    task automatic value_mismatch(input string sig, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
        $display("[FAIL] %0t ns %s expected %h got %h", $time, sig, exp, act);
        err_cnt_o++;
        test_errs++;
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_cnt_o++;
        test_errs++;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic open_test(input nd_req_t d);
        logic [REP_W-1:0]  idx [NUM_DIM-1];
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic              zero;
        int                total;
        int                k;
        exp_waddr.delete();
        exp_wdata.delete();
        zero  = 1'b0;
        total = 1;
        for (int n = 0; n < NUM_DIM-1; n++) begin
            idx[n] = '0;
            zero   = zero | (d.dims[n].reps == '0);
            total  = total * d.dims[n].reps;
        end
        src         = d.base.src_addr;
        dst         = d.base.dst_addr;
        test_bursts = zero ? 0 : total;
        for (int b = 0; b < test_bursts; b++) begin
            for (int w = 0; w < d.base.len; w++) begin
                exp_waddr.push_back(dst + ADDR_W'(w));
                exp_wdata.push_back(mem_word(src + ADDR_W'(w)));
            end
            // Dimensions on their final pass wrap and the next one out steps
            k = 0;
            while (k < NUM_DIM-1 && idx[k] == d.dims[k].reps - 1) begin
                idx[k] = '0;
                k++;
            end
            if (k < NUM_DIM-1) begin
                idx[k]++;
                src = src + d.dims[k].src_stride;
                dst = dst + d.dims[k].dst_stride;
            end
        end
        if (zero) begin
            exp_rsp = '{error: 1'b1, err_type: ERR_ND_ZERO, last: 1'b1};
        end else if (d.base.len == '0) begin
            exp_rsp = '{error: 1'b1, err_type: ERR_BURST_ZERO, last: 1'b1};
        end else begin
            exp_rsp = '{error: 1'b0, err_type: ERR_NONE, last: 1'b1};
        end
        test_idx++;
        test_errs = 0;
        active    = 1'b1;
        accepted  = 1'b0;
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d: ok, %0d bursts", test_idx, test_bursts);
        end else begin
            fail_cnt++;
            $display("test %0d: %0d errors", test_idx, test_errs);
        end
        done_cnt_o++;
        active   = 1'b0;
        accepted = 1'b0;
    endtask

    // Outputs quiet right after reset
    task automatic check_reset();
        test_errs = 0;
        if (busy_i)         value_mismatch("busy_o", '0, DATA_W'(busy_i));
        if (nd_req_ready_i) value_mismatch("nd_req_ready_o", '0, DATA_W'(nd_req_ready_i));
        if (nd_rsp_valid_i) value_mismatch("nd_rsp_valid_o", '0, DATA_W'(nd_rsp_valid_i));
        if (mem_re_i)       value_mismatch("mem_re_o", '0, DATA_W'(mem_re_i));
        if (mem_we_i)       value_mismatch("mem_we_o", '0, DATA_W'(mem_we_i));
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test reset: ok");
        end else begin
            fail_cnt++;
            $display("test reset: %0d errors", test_errs);
        end
    endtask

    task automatic check_write();
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
        if (!active || exp_waddr.size() == 0) begin
            protocol_error($sformatf("unexpected write of %h to %h", mem_wdata_i, mem_waddr_i));
        end else begin
            waddr = exp_waddr.pop_front();
            wdata = exp_wdata.pop_front();
            if (mem_waddr_i != waddr) begin
                value_mismatch("mem_waddr_o", DATA_W'(waddr), DATA_W'(mem_waddr_i));
            end
            if (mem_wdata_i != wdata) begin
                value_mismatch("mem_wdata_o", wdata, mem_wdata_i);
            end
        end
    endtask

    task automatic check_rsp();
        // A stalled response keeps its value
        if (held) begin
            if (!nd_rsp_valid_i) begin
                protocol_error("nd_rsp_valid_o dropped before the handshake");
            end else if (nd_rsp_i != held_rsp) begin
                value_mismatch("nd_rsp_o", DATA_W'(held_rsp), DATA_W'(nd_rsp_i));
            end
        end
        held     = nd_rsp_valid_i && !nd_rsp_ready_i;
        held_rsp = nd_rsp_i;
        if (nd_rsp_valid_i && nd_rsp_ready_i) begin
            if (!active) begin
                protocol_error("response with no descriptor outstanding");
            end else begin
                if (!accepted) begin
                    protocol_error("response before the descriptor was accepted");
                end
                if (exp_waddr.size() != 0) begin
                    protocol_error($sformatf("response with %0d writes missing",
                                             exp_waddr.size()));
                end
                if (nd_rsp_i.error != exp_rsp.error) begin
                    value_mismatch("nd_rsp_o.error", DATA_W'(exp_rsp.error),
                                   DATA_W'(nd_rsp_i.error));
                end
                if (nd_rsp_i.err_type != exp_rsp.err_type) begin
                    value_mismatch("nd_rsp_o.err_type", DATA_W'(exp_rsp.err_type),
                                   DATA_W'(nd_rsp_i.err_type));
                end
                if (nd_rsp_i.last != exp_rsp.last) begin
                    value_mismatch("nd_rsp_o.last", DATA_W'(exp_rsp.last),
                                   DATA_W'(nd_rsp_i.last));
                end
                rsp_taken = 1'b1;
            end
        end
    endtask

    // ------------------------------
    // Watch at the falling edge
    // ------------------------------
    always @(negedge clk_i) begin : proc_watch
        if (rst_n_i) begin
            if (!reset_checked) begin
                check_reset();
                reset_checked = 1'b1;
            end
            // Busy must be gone a cycle after the response handshake
            if (rsp_taken) begin
                if (busy_i) begin
                    value_mismatch("busy_o", '0, DATA_W'(busy_i));
                end
                rsp_taken = 1'b0;
                close_test();
            end
            if (nd_req_valid_i && !active) begin
                open_test(nd_req_i);
            end
            if (nd_req_valid_i && nd_req_ready_i) begin
                accepted = 1'b1;
            end
            if (mem_we_i) begin
                check_write();
            end
            check_rsp();
        end
    end

    always @(posedge finish_i) begin : proc_summary
        if (active) begin
            protocol_error($sformatf("test %0d never completed", test_idx));
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    end

endmodule

`default_nettype wire

// File: tb/tb_nd_dma.sv
// ------------------------------
// ND DMA testbench top
// Clock, reset, random descriptors, source memory
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_nd_dma import nd_dma_pkg::*; ();

    localparam int                NUM_DESC  = 40;
    localparam int                TIMEOUT   = 2000;
    localparam logic [DATA_W-1:0] IDLE_WORD = 32'h0BAD_F00D;

    logic              clk;
    logic              rst_n;
    nd_req_t           nd_req;
    logic              nd_req_valid;
    logic              nd_req_ready;
    dma_rsp_t          nd_rsp;
    logic              nd_rsp_valid;
    logic              nd_rsp_ready;
    logic [ADDR_W-1:0] mem_raddr;
    logic              mem_re;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_waddr;
    logic [DATA_W-1:0] mem_wdata;
    logic              busy;
    logic              finish;
    int                err_cnt;
    int                done_cnt;
    logic [31:0]       rng;
    // Read seen at the last falling edge
    logic              rd_pend;
    logic [ADDR_W-1:0] rd_addr;
    logic              run_ok;

    always #10 clk = ~clk;

    nd_dma_top UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .nd_req_i       (nd_req),
        .nd_req_valid_i (nd_req_valid),
        .nd_req_ready_o (nd_req_ready),
        .nd_rsp_o       (nd_rsp),
        .nd_rsp_valid_o (nd_rsp_valid),
        .nd_rsp_ready_i (nd_rsp_ready),
        .mem_raddr_o    (mem_raddr),
        .mem_re_o       (mem_re),
        .mem_rdata_i    (mem_rdata),
        .mem_we_o       (mem_we),
        .mem_waddr_o    (mem_waddr),
        .mem_wdata_o    (mem_wdata),
        .busy_o         (busy)
    );

    nd_dma_checker u_chk (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .nd_req_i       (nd_req),
        .nd_req_valid_i (nd_req_valid),
        .nd_req_ready_i (nd_req_ready),
        .nd_rsp_i       (nd_rsp),
        .nd_rsp_valid_i (nd_rsp_valid),
        .nd_rsp_ready_i (nd_rsp_ready),
        .mem_re_i       (mem_re),
        .mem_we_i       (mem_we),
        .mem_waddr_i    (mem_waddr),
        .mem_wdata_i    (mem_wdata),
        .busy_i         (busy),
        .finish_i       (finish),
        .err_cnt_o      (err_cnt),
        .done_cnt_o     (done_cnt)
    );

    // ------------------------------
    // Source memory with one cycle latency
    // ------------------------------
    always @(negedge clk) begin : proc_mem_sample
        rd_pend <= mem_re;
        rd_addr <= mem_raddr;
    end

    always @(posedge clk) begin : proc_mem_drive
        #2;
        mem_rdata = rd_pend ? u_chk.mem_word(rd_addr) : IDLE_WORD;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    // Slot 3 of every 8 gets a zero repetition and slot 6 a zero length
    task automatic make_desc(input int n, output nd_req_t d, output logic zero);
        logic [31:0] r;
        int          kind;
        kind = n % 8;
        roll(r);
        d.base.src_addr = r[15:0];
        d.base.dst_addr = r[31:16];
        roll(r);
        d.base.len  = (kind == 6) ? '0 : LEN_W'(1 + r[7:0] % 4);
        d.base.last = 1'b0;
        for (int i = 0; i < NUM_DIM-1; i++) begin
            roll(r);
            d.dims[i].reps       = REP_W'(1 + r[7:0] % 3);
            d.dims[i].src_stride = r[31:16];
            roll(r);
            d.dims[i].dst_stride = r[15:0];
        end
        zero = (kind == 3);
        if (zero) begin
            roll(r);
            d.dims[r[0]].reps = '0;
            if (r[1]) begin
                d.dims[!r[0]].reps = '0;
            end
        end
    endtask

    // Present one descriptor and run until accepted and answered
    task automatic run_desc(input int n, input nd_req_t d, input logic zero, output logic ok);
        logic [31:0] r;
        logic        taken;
        logic        got_rsp;
        int          cycles;
        taken   = 1'b0;
        got_rsp = 1'b0;
        cycles  = 0;
        @(posedge clk);
        #2;
        nd_req       = d;
        nd_req_valid = 1'b1;
        roll(r);
        // A rejection answers in the cycle it is presented
        nd_rsp_ready = zero | (r[2:0] > 3'd2);
        while (!(taken && got_rsp) && cycles < TIMEOUT) begin
            @(negedge clk);
            if (nd_req_valid && nd_req_ready) begin
                taken = 1'b1;
            end
            if (nd_rsp_valid && nd_rsp_ready) begin
                got_rsp = 1'b1;
            end
            @(posedge clk);
            #2;
            if (taken) begin
                nd_req_valid = 1'b0;
            end
            // Random stretches of back-pressure
            roll(r);
            nd_rsp_ready = (zero && !taken) | (r[2:0] > 3'd2);
            cycles++;
        end
        ok = taken && got_rsp;
        if (!ok) begin
            $display("timeout: descriptor %0d stuck, accepted %0b, response %0b",
                     n, taken, got_rsp);
        end
    endtask

    initial begin : proc_main
        nd_req_t d;
        logic    zero;
        logic    ok;
        int      n;
        clk          = 1'b0;
        rst_n        = 1'b0;
        rng          = 32'd37;
        nd_req       = '0;
        nd_req_valid = 1'b0;
        nd_rsp_ready = 1'b0;
        mem_rdata    = IDLE_WORD;
        rd_pend      = 1'b0;
        rd_addr      = '0;
        finish       = 1'b0;
        run_ok       = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        n = 0;
        while (run_ok && n < NUM_DESC) begin
            make_desc(n, d, zero);
            run_desc(n, d, zero, ok);
            run_ok = ok;
            n++;
        end
        // Room for the final busy check
        repeat (2) @(posedge clk);
        finish = 1'b1;
        #1;
        if (run_ok && err_cnt == 0 && done_cnt == NUM_DESC) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/nd_dma_pkg.sv
rtl/nd_rep_counter.sv
rtl/nd_midend.sv
rtl/burst_copy_backend.sv
rtl/nd_dma_top.sv
tb/nd_dma_checker.sv
tb/tb_nd_dma.sv
